//--- rename_pkg.sv
package rename_pkg;

  //////////////////////////////////////////////////////////////////////
  // Default sizes handed down by the top level
  //////////////////////////////////////////////////////////////////////

  // Micro-ops renamed per group
  localparam int RENAME_WIDTH_DEF = 2;

  // Architectural integer registers
  localparam int ARCH_REGS_DEF = 16;

  // Physical integer registers
  // Index 0 is never allocated
  localparam int PHYS_REGS_DEF = 32;

  // Branch checkpoint slots
  localparam int CKPT_COUNT_DEF = 4;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Per-lane micro-op kind
  // A write to architectural register 0 behaves as OP_NODEST
  typedef enum logic [1:0] {
    OP_NONE   = 2'd0,
    OP_NODEST = 2'd1,
    OP_WRITE  = 2'd2,
    OP_BRANCH = 2'd3
  } op_kind_e;

  // Controller state
  // One recover cycle follows each restore
  typedef enum logic {
    CTRL_RUN     = 1'b0,
    CTRL_RECOVER = 1'b1
  } ctrl_state_e;

endpackage

//--- rename_ifs.sv
`timescale 1ns/1ps

// Allocation request and grant between controller and free list
interface alloc_if #(
  parameter int RENAME_WIDTH = 2,
  parameter int PHYS_REGS    = 32
);

  localparam int PW = $clog2(PHYS_REGS);

  logic [RENAME_WIDTH-1:0]         req;
  logic                            fire;
  logic                            ok;
  logic [RENAME_WIDTH-1:0][PW-1:0] preg;

  modport ctrl (output req, output fire, input ok, input preg);
  modport list (input req, input fire, output ok, output preg);

endinterface

// Checkpoint take and restore, fanned out to free list and map table
interface ckpt_if #(
  parameter int CKPT_COUNT = 4
);

  localparam int CW = $clog2(CKPT_COUNT);

  logic          take;
  logic [CW-1:0] take_id;
  logic          restore;
  logic [CW-1:0] restore_id;

  modport src (output take, output take_id, output restore, output restore_id);
  modport sink (input take, input take_id, input restore, input restore_id);

endinterface

//--- free_list.sv
`timescale 1ns/1ps

module free_list #(
  parameter int RENAME_WIDTH = rename_pkg::RENAME_WIDTH_DEF,
  parameter int ARCH_REGS    = rename_pkg::ARCH_REGS_DEF,
  parameter int PHYS_REGS    = rename_pkg::PHYS_REGS_DEF,
  parameter int CKPT_COUNT   = rename_pkg::CKPT_COUNT_DEF,
  localparam int PW          = $clog2(PHYS_REGS)
) (
  input  logic                            clock,
  input  logic                            reset,
  alloc_if.list                           alloc,
  ckpt_if.sink                            ckpt,
  input  logic [RENAME_WIDTH-1:0]         commit_valid,
  input  logic [RENAME_WIDTH-1:0][PW-1:0] commit_preg
);

  localparam int CW = $clog2(CKPT_COUNT);

  // One bit per physical register, set means busy
  logic [PHYS_REGS-1:0] busy;
  logic [PHYS_REGS-1:0] ckpt_busy [CKPT_COUNT];

  logic [PHYS_REGS-1:0] free_mask;
  logic [PHYS_REGS-1:0] busy_merged;
  logic [PHYS_REGS-1:0] busy_alloc;
  logic [PHYS_REGS-1:0] busy_next;

  // Registers returned by commit this cycle
  always_comb begin
    free_mask = '0;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      if (commit_valid[l]) begin
        free_mask[commit_preg[l]] = 1'b1;
      end
    end
  end

  // Lowest free index per requesting lane, lanes in order
  always_comb begin
    logic found;
    found       = 1'b0;
    busy_merged = busy & ~free_mask;
    busy_alloc  = busy_merged;
    alloc.ok    = 1'b1;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      found         = 1'b0;
      alloc.preg[l] = '0;
      if (alloc.req[l]) begin
        for (int i = 0; i < PHYS_REGS; i++) begin
          if (!found && !busy_alloc[i]) begin
            found         = 1'b1;
            alloc.preg[l] = PW'(i);
            busy_alloc[i] = 1'b1;
          end
        end
        // Not enough free registers for the whole group
        if (!found) begin
          alloc.ok = 1'b0;
        end
      end
    end
  end

  assign busy_next = alloc.fire ? busy_alloc : busy_merged;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        busy[i] <= (i < ARCH_REGS);
      end
    end else if (ckpt.restore) begin
      busy <= ckpt_busy[ckpt.restore_id] & ~free_mask;
    end else begin
      busy <= busy_next;
    end
  end

  // Checkpoint copies
  // Commits clear their bits in every copy
  always_ff @(posedge clock) begin
    for (int s = 0; s < CKPT_COUNT; s++) begin
      if (ckpt.take && !ckpt.restore && ckpt.take_id == CW'(s)) begin
        ckpt_busy[s] <= busy_next;
      end else begin
        ckpt_busy[s] <= ckpt_busy[s] & ~free_mask;
      end
    end
  end

  for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_check
    // Register 0 stays reserved for architectural register 0
    assert property (@(posedge clock) disable iff (reset)
      (alloc.fire && alloc.req[g]) |-> (alloc.preg[g] != '0));
    // Commit only returns registers that were handed out
    assert property (@(posedge clock) disable iff (reset)
      commit_valid[g] |-> busy[commit_preg[g]]);
  end

endmodule

//--- map_table.sv
`timescale 1ns/1ps

module map_table #(
  parameter int RENAME_WIDTH = rename_pkg::RENAME_WIDTH_DEF,
  parameter int ARCH_REGS    = rename_pkg::ARCH_REGS_DEF,
  parameter int PHYS_REGS    = rename_pkg::PHYS_REGS_DEF,
  parameter int CKPT_COUNT   = rename_pkg::CKPT_COUNT_DEF,
  localparam int AW          = $clog2(ARCH_REGS),
  localparam int PW          = $clog2(PHYS_REGS)
) (
  input  logic                                  clock,
  input  logic                                  reset,
  ckpt_if.sink                                  ckpt,
  input  logic                                  fire,
  input  rename_pkg::op_kind_e [RENAME_WIDTH-1:0] kind,
  input  logic [RENAME_WIDTH-1:0][AW-1:0]       dest,
  input  logic [RENAME_WIDTH-1:0][AW-1:0]       src1,
  input  logic [RENAME_WIDTH-1:0][AW-1:0]       src2,
  input  logic [RENAME_WIDTH-1:0][PW-1:0]       new_preg,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       psrc1,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       psrc2,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       old_pdest
);

  import rename_pkg::*;

  logic [PW-1:0] map      [ARCH_REGS];
  logic [PW-1:0] map_next [ARCH_REGS];
  logic [PW-1:0] ckpt_map [CKPT_COUNT][ARCH_REGS];

  logic [RENAME_WIDTH-1:0] writes;

  // Lanes that write a destination other than r0
  always_comb begin
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      writes[l] = (kind[l] == OP_WRITE) && (dest[l] != '0);
    end
  end

  // Table read, then bypass from earlier writers in the group
  always_comb begin
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      psrc1[l]     = map[src1[l]];
      psrc2[l]     = map[src2[l]];
      old_pdest[l] = map[dest[l]];
      // Later matching lane overrides an earlier one
      for (int j = 0; j < l; j++) begin
        if (writes[j] && dest[j] == src1[l]) begin
          psrc1[l] = new_preg[j];
        end
        if (writes[j] && dest[j] == src2[l]) begin
          psrc2[l] = new_preg[j];
        end
        if (writes[j] && dest[j] == dest[l]) begin
          old_pdest[l] = new_preg[j];
        end
      end
    end
  end

  always_comb begin
    map_next = map;
    if (fire) begin
      for (int l = 0; l < RENAME_WIDTH; l++) begin
        if (writes[l]) begin
          map_next[dest[l]] = new_preg[l];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < ARCH_REGS; a++) begin
        map[a] <= PW'(a);
      end
    end else if (ckpt.restore) begin
      map <= ckpt_map[ckpt.restore_id];
    end else begin
      map <= map_next;
    end
  end

  // Snapshot includes the branch group's own writes
  always_ff @(posedge clock) begin
    if (ckpt.take && !ckpt.restore) begin
      ckpt_map[ckpt.take_id] <= map_next;
    end
  end

  assert property (@(posedge clock) disable iff (reset) map[0] == '0);

endmodule

//--- rename_ctrl.sv
`timescale 1ns/1ps

module rename_ctrl #(
  parameter int RENAME_WIDTH = rename_pkg::RENAME_WIDTH_DEF,
  parameter int ARCH_REGS    = rename_pkg::ARCH_REGS_DEF,
  parameter int PHYS_REGS    = rename_pkg::PHYS_REGS_DEF,
  parameter int CKPT_COUNT   = rename_pkg::CKPT_COUNT_DEF,
  localparam int AW          = $clog2(ARCH_REGS),
  localparam int PW          = $clog2(PHYS_REGS),
  localparam int CW          = $clog2(CKPT_COUNT)
) (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  in_valid,
  input  rename_pkg::op_kind_e [RENAME_WIDTH-1:0] in_kind,
  input  logic [RENAME_WIDTH-1:0][AW-1:0]       in_dest,
  output logic                                  in_ready,
  input  logic                                  out_ready,
  output logic                                  out_valid,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       out_psrc1,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       out_psrc2,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       out_pdest,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       out_old_pdest,
  output logic                                  out_ckpt_valid,
  output logic [CW-1:0]                         out_ckpt_id,
  input  logic [RENAME_WIDTH-1:0][PW-1:0]       psrc1,
  input  logic [RENAME_WIDTH-1:0][PW-1:0]       psrc2,
  input  logic [RENAME_WIDTH-1:0][PW-1:0]       old_pdest,
  alloc_if.ctrl                                 alloc,
  ckpt_if.src                                   ckpt,
  input  logic                                  resolve_valid,
  input  logic [CW-1:0]                         resolve_cp,
  input  logic                                  recover_valid,
  input  logic [CW-1:0]                         recover_cp
);

  import rename_pkg::*;

  ctrl_state_e state;

  logic [CKPT_COUNT-1:0] slot_busy;
  // older[i][j] set when slot j was taken before slot i
  logic [CKPT_COUNT-1:0] older [CKPT_COUNT];
  logic [CW-1:0]         free_id;
  logic                  slot_avail;

  logic has_branch;
  logic out_take;
  logic fire;

  //////////////////////////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    has_branch = 1'b0;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      alloc.req[l] = (in_kind[l] == OP_WRITE) && (in_dest[l] != '0);
      if (in_kind[l] == OP_BRANCH) begin
        has_branch = 1'b1;
      end
    end
  end

  // Lowest free checkpoint slot
  always_comb begin
    slot_avail = 1'b0;
    free_id    = '0;
    for (int s = CKPT_COUNT - 1; s >= 0; s--) begin
      if (!slot_busy[s]) begin
        slot_avail = 1'b1;
        free_id    = CW'(s);
      end
    end
  end

  assign out_take = !out_valid || out_ready;
  assign in_ready = (state == CTRL_RUN) && !recover_valid && out_take && alloc.ok &&
                    (!has_branch || slot_avail);
  assign fire     = in_valid && in_ready;

  assign alloc.fire      = fire;
  assign ckpt.take       = fire && has_branch;
  assign ckpt.take_id    = free_id;
  assign ckpt.restore    = recover_valid;
  assign ckpt.restore_id = recover_cp;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= CTRL_RUN;
    end else if (recover_valid) begin
      state <= CTRL_RECOVER;
    end else begin
      state <= CTRL_RUN;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checkpoint slots and age order
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      slot_busy <= '0;
      for (int s = 0; s < CKPT_COUNT; s++) begin
        older[s] <= '0;
      end
    end else begin
      for (int s = 0; s < CKPT_COUNT; s++) begin
        // Recover drops the slot and everything younger
        if (recover_valid && (CW'(s) == recover_cp || older[s][recover_cp])) begin
          slot_busy[s] <= 1'b0;
        end else if (resolve_valid && CW'(s) == resolve_cp) begin
          slot_busy[s] <= 1'b0;
        end else if (ckpt.take && ckpt.take_id == CW'(s)) begin
          slot_busy[s] <= 1'b1;
        end
        if (ckpt.take) begin
          if (ckpt.take_id == CW'(s)) begin
            older[s] <= slot_busy;
          end else begin
            older[s][ckpt.take_id] <= 1'b0;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset || recover_valid) begin
      out_valid <= 1'b0;
    end else if (out_take) begin
      out_valid <= fire;
    end
  end

  always_ff @(posedge clock) begin
    if (fire) begin
      out_psrc1      <= psrc1;
      out_psrc2      <= psrc2;
      out_ckpt_valid <= has_branch;
      out_ckpt_id    <= free_id;
      for (int l = 0; l < RENAME_WIDTH; l++) begin
        out_pdest[l]     <= alloc.req[l] ? alloc.preg[l] : '0;
        out_old_pdest[l] <= alloc.req[l] ? old_pdest[l] : '0;
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) alloc.fire |-> alloc.ok);
  assert property (@(posedge clock) disable iff (reset) ckpt.take |-> !slot_busy[ckpt.take_id]);

endmodule

//--- rename_unit.sv
`timescale 1ns/1ps

module rename_unit #(
  parameter int RENAME_WIDTH = rename_pkg::RENAME_WIDTH_DEF,
  parameter int ARCH_REGS    = rename_pkg::ARCH_REGS_DEF,
  parameter int PHYS_REGS    = rename_pkg::PHYS_REGS_DEF,
  parameter int CKPT_COUNT   = rename_pkg::CKPT_COUNT_DEF,
  localparam int AW          = $clog2(ARCH_REGS),
  localparam int PW          = $clog2(PHYS_REGS),
  localparam int CW          = $clog2(CKPT_COUNT)
) (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  input  rename_pkg::op_kind_e [RENAME_WIDTH-1:0] in_kind,
  input  logic [RENAME_WIDTH-1:0][AW-1:0]       in_dest,
  input  logic [RENAME_WIDTH-1:0][AW-1:0]       in_src1,
  input  logic [RENAME_WIDTH-1:0][AW-1:0]       in_src2,
  output logic                                  out_valid,
  input  logic                                  out_ready,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       out_psrc1,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       out_psrc2,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       out_pdest,
  output logic [RENAME_WIDTH-1:0][PW-1:0]       out_old_pdest,
  output logic                                  out_ckpt_valid,
  output logic [CW-1:0]                         out_ckpt_id,
  input  logic [RENAME_WIDTH-1:0]               commit_valid,
  input  logic [RENAME_WIDTH-1:0][PW-1:0]       commit_preg,
  input  logic                                  resolve_valid,
  input  logic [CW-1:0]                         resolve_cp,
  input  logic                                  recover_valid,
  input  logic [CW-1:0]                         recover_cp
);

  // Renamed sources and old destinations from the map table
  logic [RENAME_WIDTH-1:0][PW-1:0] psrc1;
  logic [RENAME_WIDTH-1:0][PW-1:0] psrc2;
  logic [RENAME_WIDTH-1:0][PW-1:0] old_pdest;

  alloc_if #(.RENAME_WIDTH(RENAME_WIDTH), .PHYS_REGS(PHYS_REGS)) alloc_bus ();
  ckpt_if #(.CKPT_COUNT(CKPT_COUNT)) ckpt_bus ();

  rename_ctrl #(
    .RENAME_WIDTH(RENAME_WIDTH),
    .ARCH_REGS(ARCH_REGS),
    .PHYS_REGS(PHYS_REGS),
    .CKPT_COUNT(CKPT_COUNT)
  ) rename_ctrl_inst (
    .clock(clock),
    .reset(reset),
    .in_valid(in_valid),
    .in_kind(in_kind),
    .in_dest(in_dest),
    .in_ready(in_ready),
    .out_ready(out_ready),
    .out_valid(out_valid),
    .out_psrc1(out_psrc1),
    .out_psrc2(out_psrc2),
    .out_pdest(out_pdest),
    .out_old_pdest(out_old_pdest),
    .out_ckpt_valid(out_ckpt_valid),
    .out_ckpt_id(out_ckpt_id),
    .psrc1(psrc1),
    .psrc2(psrc2),
    .old_pdest(old_pdest),
    .alloc(alloc_bus.ctrl),
    .ckpt(ckpt_bus.src),
    .resolve_valid(resolve_valid),
    .resolve_cp(resolve_cp),
    .recover_valid(recover_valid),
    .recover_cp(recover_cp)
  );

  free_list #(
    .RENAME_WIDTH(RENAME_WIDTH),
    .ARCH_REGS(ARCH_REGS),
    .PHYS_REGS(PHYS_REGS),
    .CKPT_COUNT(CKPT_COUNT)
  ) free_list_inst (
    .clock(clock),
    .reset(reset),
    .alloc(alloc_bus.list),
    .ckpt(ckpt_bus.sink),
    .commit_valid(commit_valid),
    .commit_preg(commit_preg)
  );

  map_table #(
    .RENAME_WIDTH(RENAME_WIDTH),
    .ARCH_REGS(ARCH_REGS),
    .PHYS_REGS(PHYS_REGS),
    .CKPT_COUNT(CKPT_COUNT)
  ) map_table_inst (
    .clock(clock),
    .reset(reset),
    .ckpt(ckpt_bus.sink),
    .fire(alloc_bus.fire),
    .kind(in_kind),
    .dest(in_dest),
    .src1(in_src1),
    .src2(in_src2),
    .new_preg(alloc_bus.preg),
    .psrc1(psrc1),
    .psrc2(psrc2),
    .old_pdest(old_pdest)
  );

endmodule

//--- tb_rename_unit.sv
`timescale 1ns/1ps

module tb_rename_unit;

  import rename_pkg::*;

  localparam int W           = RENAME_WIDTH_DEF;
  localparam int ARCH        = ARCH_REGS_DEF;
  localparam int PHYS        = PHYS_REGS_DEF;
  localparam int CK          = CKPT_COUNT_DEF;
  localparam int AW          = $clog2(ARCH);
  localparam int PW          = $clog2(PHYS);
  localparam int CW          = $clog2(CK);
  localparam int NUM_GROUPS  = 300;
  localparam int CYCLE_LIMIT = 2 * NUM_GROUPS + 200;

  logic                 clock;
  logic                 reset;
  logic                 in_valid;
  logic                 in_ready;
  op_kind_e [W-1:0]     in_kind;
  logic [W-1:0][AW-1:0] in_dest;
  logic [W-1:0][AW-1:0] in_src1;
  logic [W-1:0][AW-1:0] in_src2;
  logic                 out_valid;
  logic                 out_ready;
  logic [W-1:0][PW-1:0] out_psrc1;
  logic [W-1:0][PW-1:0] out_psrc2;
  logic [W-1:0][PW-1:0] out_pdest;
  logic [W-1:0][PW-1:0] out_old_pdest;
  logic                 out_ckpt_valid;
  logic [CW-1:0]        out_ckpt_id;
  logic [W-1:0]         commit_valid;
  logic [W-1:0][PW-1:0] commit_preg;
  logic                 resolve_valid;
  logic [CW-1:0]        resolve_cp;
  logic                 recover_valid;
  logic [CW-1:0]        recover_cp;

  //////////////////////////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////////////////////////

  int m_map [ARCH];
  bit m_busy [PHYS];
  int ck_map [CK][ARCH];
  bit ck_busy [CK][PHYS];
  bit ck_live [CK];
  // Group number that took each slot, orders slots by age
  int ck_seq [CK];
  // Old destinations not yet committed, tagged with their group number
  int pend_preg [$];
  int pend_seq [$];

  // Expected content of the output register
  bit e_valid;
  int e_psrc1 [W];
  int e_psrc2 [W];
  int e_pdest [W];
  int e_old [W];
  bit e_ckv;
  int e_ckid;
  bit rec_prev;

  int group_seq = 0;
  int accepted  = 0;
  int cycles    = 0;
  int checks    = 0;
  int errors    = 0;

  rename_unit rename_unit_inst (.*);

  always #50 clock = ~clock;

  task automatic report_mismatch(string name, int expected, int actual);
    errors++;
    $display("FAIL %s expected %0d actual %0d", name, expected, actual);
  endtask

  // New random inputs, applied at the rising edge
  task automatic drive_inputs();
    bit br;
    int k;
    int idx;
    int lim;
    int s;
    int n_live;
    br = 1'b0;
    in_valid  <= ($urandom % 8) != 0;
    out_ready <= ($urandom % 4) != 0;
    for (int l = 0; l < W; l++) begin
      k = $urandom % 8;
      if (k == 7 && !br) begin
        br = 1'b1;
        in_kind[l] <= OP_BRANCH;
      end else if (k >= 2) begin
        in_kind[l] <= OP_WRITE;
      end else if (k == 1) begin
        in_kind[l] <= OP_NODEST;
      end else begin
        in_kind[l] <= OP_NONE;
      end
      in_dest[l] <= AW'($urandom % ARCH);
      in_src1[l] <= AW'($urandom % ARCH);
      in_src2[l] <= AW'($urandom % ARCH);
    end
    // Only uops older than every live branch may commit
    lim = group_seq;
    n_live = 0;
    for (s = 0; s < CK; s++) begin
      if (ck_live[s]) begin
        n_live++;
        if (ck_seq[s] < lim) begin
          lim = ck_seq[s];
        end
      end
    end
    for (int l = 0; l < W; l++) begin
      commit_valid[l] <= 1'b0;
      commit_preg[l]  <= '0;
      if (pend_preg.size() > 0 && ($urandom % 4) != 0) begin
        idx = $urandom % pend_preg.size();
        if (pend_seq[idx] <= lim) begin
          commit_valid[l] <= 1'b1;
          commit_preg[l]  <= PW'(pend_preg[idx]);
          pend_preg.delete(idx);
          pend_seq.delete(idx);
        end
      end
    end
    resolve_valid <= 1'b0;
    recover_valid <= 1'b0;
    if (n_live > 0) begin
      k = $urandom % 32;
      s = $urandom % CK;
      while (!ck_live[s]) begin
        s = (s + 1) % CK;
      end
      if (k == 0) begin
        recover_valid <= 1'b1;
        recover_cp    <= CW'(s);
      end else if (k < 8) begin
        resolve_valid <= 1'b1;
        resolve_cp    <= CW'(s);
      end
    end
  endtask

  // Checks the stable outputs, then applies the coming edge to the model
  task automatic step_model();
    bit taken [PHYS];
    int wm [ARCH];
    int np [W];
    int od;
    int slot;
    int cp;
    bit ok;
    bit has_br;
    bit wr;
    bit exp_ready;
    checks++;
    if (out_valid !== e_valid) begin
      report_mismatch("out_valid", int'(e_valid), int'(out_valid));
    end
    if (e_valid) begin
      for (int l = 0; l < W; l++) begin
        if (out_psrc1[l] !== PW'(e_psrc1[l])) begin
          report_mismatch($sformatf("psrc1 lane %0d", l), e_psrc1[l], int'(out_psrc1[l]));
        end
        if (out_psrc2[l] !== PW'(e_psrc2[l])) begin
          report_mismatch($sformatf("psrc2 lane %0d", l), e_psrc2[l], int'(out_psrc2[l]));
        end
        if (out_pdest[l] !== PW'(e_pdest[l])) begin
          report_mismatch($sformatf("pdest lane %0d", l), e_pdest[l], int'(out_pdest[l]));
        end
        if (out_old_pdest[l] !== PW'(e_old[l])) begin
          report_mismatch($sformatf("old_pdest lane %0d", l), e_old[l],
                          int'(out_old_pdest[l]));
        end
      end
      if (out_ckpt_valid !== e_ckv) begin
        report_mismatch("ckpt_valid", int'(e_ckv), int'(out_ckpt_valid));
      end
      if (e_ckv && out_ckpt_id !== CW'(e_ckid)) begin
        report_mismatch("ckpt_id", e_ckid, int'(out_ckpt_id));
      end
    end
    // Commit frees come first and reach every checkpoint copy
    for (int l = 0; l < W; l++) begin
      if (commit_valid[l]) begin
        m_busy[commit_preg[l]] = 1'b0;
        for (int s = 0; s < CK; s++) begin
          ck_busy[s][commit_preg[l]] = 1'b0;
        end
      end
    end
    taken = m_busy;
    ok = 1'b1;
    has_br = 1'b0;
    for (int l = 0; l < W; l++) begin
      np[l] = 0;
      if (in_kind[l] == OP_BRANCH) begin
        has_br = 1'b1;
      end
      if (in_kind[l] == OP_WRITE && in_dest[l] != 0) begin
        np[l] = -1;
        for (int p = PHYS - 1; p >= 0; p--) begin
          if (!taken[p]) begin
            np[l] = p;
          end
        end
        if (np[l] < 0) begin
          ok = 1'b0;
        end else begin
          taken[np[l]] = 1'b1;
        end
      end
    end
    slot = -1;
    for (int s = CK - 1; s >= 0; s--) begin
      if (!ck_live[s]) begin
        slot = s;
      end
    end
    exp_ready = !rec_prev && !recover_valid && (!e_valid || out_ready) && ok &&
                (!has_br || slot >= 0);
    if (in_ready !== exp_ready) begin
      report_mismatch("in_ready", int'(exp_ready), int'(in_ready));
    end
    rec_prev = recover_valid;
    if (recover_valid) begin
      cp = recover_cp;
      m_map  = ck_map[cp];
      m_busy = ck_busy[cp];
      for (int s = 0; s < CK; s++) begin
        if (ck_live[s] && ck_seq[s] > ck_seq[cp]) begin
          ck_live[s] = 1'b0;
        end
      end
      ck_live[cp] = 1'b0;
      // Uops renamed after the branch are squashed
      for (int i = pend_seq.size() - 1; i >= 0; i--) begin
        if (pend_seq[i] > ck_seq[cp]) begin
          pend_preg.delete(i);
          pend_seq.delete(i);
        end
      end
      e_valid = 1'b0;
    end else begin
      if (resolve_valid) begin
        ck_live[resolve_cp] = 1'b0;
      end
      if (e_valid && out_ready) begin
        e_valid = 1'b0;
      end
      if (in_valid && exp_ready) begin
        // Lanes in program order, later lanes see earlier writes
        wm = m_map;
        for (int l = 0; l < W; l++) begin
          wr = (in_kind[l] == OP_WRITE) && (in_dest[l] != 0);
          e_psrc1[l] = wm[in_src1[l]];
          e_psrc2[l] = wm[in_src2[l]];
          od = wm[in_dest[l]];
          e_pdest[l] = wr ? np[l] : 0;
          e_old[l] = wr ? od : 0;
          if (wr) begin
            wm[in_dest[l]] = np[l];
            m_busy[np[l]] = 1'b1;
            pend_preg.push_back(od);
            pend_seq.push_back(group_seq);
          end
        end
        m_map = wm;
        e_ckv = has_br;
        e_ckid = slot;
        if (has_br) begin
          ck_map[slot]  = m_map;
          ck_busy[slot] = m_busy;
          ck_live[slot] = 1'b1;
          ck_seq[slot]  = group_seq;
        end
        e_valid = 1'b1;
        group_seq++;
        accepted++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(63));
    clock = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    for (int l = 0; l < W; l++) begin
      in_kind[l] = OP_NONE;
    end
    in_dest = '0;
    in_src1 = '0;
    in_src2 = '0;
    out_ready = 1'b0;
    commit_valid = '0;
    commit_preg = '0;
    resolve_valid = 1'b0;
    resolve_cp = '0;
    recover_valid = 1'b0;
    recover_cp = '0;
    // Model starts from the reset mapping
    for (int a = 0; a < ARCH; a++) begin
      m_map[a] = a;
    end
    for (int p = 0; p < PHYS; p++) begin
      m_busy[p] = (p < ARCH);
    end
    for (int s = 0; s < CK; s++) begin
      ck_live[s] = 1'b0;
      ck_seq[s] = 0;
    end
    e_valid = 1'b0;
    e_ckv = 1'b0;
    rec_prev = 1'b0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    while (accepted < NUM_GROUPS && cycles < CYCLE_LIMIT) begin
      @(posedge clock);
      drive_inputs();
      @(negedge clock);
      cycles++;
      step_model();
    end
    if (accepted < NUM_GROUPS) begin
      errors++;
      $display("Timeout after %0d cycles with only %0d of %0d groups renamed",
               cycles, accepted, NUM_GROUPS);
    end
    $display("Groups: %0d, cycles: %0d, checks: %0d, errors: %0d",
             accepted, cycles, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
rename_pkg.sv
rename_ifs.sv
free_list.sv
map_table.sv
rename_ctrl.sv
rename_unit.sv
tb_rename_unit.sv

//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= tb_rename_unit
FILELIST ?= tb.f
BUILD    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(BUILD)
